// File: Bender.yml
package:
  name: mul_subsystem

sources:
  - files:
      - mul_pkg.sv
      - mul.sv
      - gpr_prf.sv
      - hilo_prf.sv
      - mul_subsystem.sv
  - target: test
    files:
      - mul_checker.sv
      - tb_mul_subsystem.sv

// File: files.f
mul_pkg.sv
mul.sv
gpr_prf.sv
hilo_prf.sv
mul_subsystem.sv
mul_checker.sv
tb_mul_subsystem.sv

// File: gpr_prf.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_prf
   import mul_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  gpr_ptr_t    rd_ptr_a,
   input  gpr_ptr_t    rd_ptr_b,
   output logic [31:0] rd_data_a,
   output logic [31:0] rd_data_b,
   input  gpr_load_t   load,
   input  mul_done_t   done
);

   localparam int N_REGS = 1 << LG_PRF_ENTRIES;

   logic [31:0] regs [0:N_REGS-1];

   // combinational reads
   assign rd_data_a = regs[rd_ptr_a];
   assign rd_data_b = regs[rd_ptr_b];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < N_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else
      begin
         if (load.en)
         begin
            regs[load.ptr] <= load.data;
         end
         // writeback goes last so it wins on the same index
         if (done.gpr_val)
         begin
            regs[done.gpr_ptr] <= done.y[31:0];
         end
      end
   end

   a_wb_ptr_known : assert property (@(posedge clk) disable iff (reset)
      done.gpr_val |-> !$isunknown(done.gpr_ptr));

endmodule

`default_nettype wire

// File: hilo_prf.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_prf
   import mul_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  hilo_ptr_t   rd_ptr,
   output logic [63:0] rd_data,
   input  hilo_load_t  load,
   input  mul_done_t   done
);

   localparam int N_REGS = 1 << LG_HILO_PRF_ENTRIES;

   // hi in the upper word, lo in the lower
   logic [63:0] regs [0:N_REGS-1];

   assign rd_data = regs[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < N_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else
      begin
         if (load.en)
         begin
            regs[load.ptr] <= load.data;
         end
         if (done.hilo_val)
         begin
            regs[done.hilo_ptr] <= done.y;
         end
      end
   end

   // a writeback from the pipeline must name a real register
   a_wb_ptr_known : assert property (@(posedge clk) disable iff (reset)
      done.hilo_val |-> !$isunknown(done.hilo_ptr));

endmodule

`default_nettype wire

// File: mul.sv
`timescale 1ns/1ps
`default_nettype none

module mul
   import mul_pkg::*;
#(
   parameter int MUL_LAT = 4
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        go,
   input  mul_tag_t    tag,
   input  logic [31:0] src_a,
   input  logic [31:0] src_b,
   input  logic [63:0] src_hilo,
   output mul_done_t   done
);

   // per-stage control, cleared on reset
   typedef struct packed {
      logic valid;
      logic gpr_val;
      logic hilo_val;
      logic acc_en;
   } stage_ctrl_t;

   // per-stage payload
   typedef struct packed {
      logic [63:0] prod;
      logic [63:0] acc;
      logic        acc_sub;
      gpr_ptr_t    gpr_ptr;
      hilo_ptr_t   hilo_ptr;
      rob_ptr_t    rob_ptr;
   } stage_data_t;

   stage_ctrl_t ctrl_in;
   stage_data_t data_in;
   stage_ctrl_t ctrl_q [0:MUL_LAT];
   stage_data_t data_q [0:MUL_LAT];

   logic [63:0] a_ext;
   logic [63:0] b_ext;
   logic [63:0] prod;
   logic [63:0] y_last;

   // extend to 64 bits, low half of the 64x64 product is the answer either way
   always_comb
   begin
      if (tag.opcode == MULTU)
      begin
         a_ext = {32'b0, src_a};
         b_ext = {32'b0, src_b};
      end
      else
      begin
         a_ext = {{32{src_a[31]}}, src_a};
         b_ext = {{32{src_b[31]}}, src_b};
      end
      prod = a_ext * b_ext;
   end

   always_comb
   begin
      ctrl_in.valid    = go;
      ctrl_in.gpr_val  = go && (tag.opcode == MUL);
      ctrl_in.hilo_val = go && (tag.opcode != MUL);
      ctrl_in.acc_en   = go && ((tag.opcode == MADD) || (tag.opcode == MSUB));

      data_in.prod     = prod;
      data_in.acc      = src_hilo;
      data_in.acc_sub  = (tag.opcode == MSUB);
      data_in.gpr_ptr  = tag.gpr_dst;
      data_in.hilo_ptr = tag.hilo_dst;
      data_in.rob_ptr  = tag.rob_ptr;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i <= MUL_LAT; i++)
         begin
            ctrl_q[i] <= '0;
         end
      end
      else
      begin
         ctrl_q[0] <= ctrl_in;
         for (int i = 1; i <= MUL_LAT; i++)
         begin
            ctrl_q[i] <= ctrl_q[i-1];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      data_q[0] <= data_in;
      for (int i = 1; i <= MUL_LAT; i++)
      begin
         data_q[i] <= data_q[i-1];
      end
   end

   // accumulate at the last stage
   always_comb
   begin
      if (ctrl_q[MUL_LAT].acc_en)
      begin
         if (data_q[MUL_LAT].acc_sub)
         begin
            y_last = data_q[MUL_LAT].acc - data_q[MUL_LAT].prod;
         end
         else
         begin
            y_last = data_q[MUL_LAT].acc + data_q[MUL_LAT].prod;
         end
      end
      else
      begin
         y_last = data_q[MUL_LAT].prod;
      end
   end

   always_comb
   begin
      done.valid    = ctrl_q[MUL_LAT].valid;
      done.rob_ptr  = data_q[MUL_LAT].rob_ptr;
      done.gpr_val  = ctrl_q[MUL_LAT].gpr_val;
      done.gpr_ptr  = data_q[MUL_LAT].gpr_ptr;
      done.hilo_val = ctrl_q[MUL_LAT].hilo_val;
      done.hilo_ptr = data_q[MUL_LAT].hilo_ptr;
      done.y        = y_last;
   end

   // issue must carry a defined opcode
   a_opcode_known : assert property (@(posedge clk) disable iff (reset)
      go |-> tag.opcode inside {MUL, MULT, MULTU, MADD, MSUB});

   // one writeback target per completion
   a_single_dest : assert property (@(posedge clk) disable iff (reset)
      !(done.gpr_val && done.hilo_val));

endmodule

`default_nettype wire

// File: mul_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mul_checker
   import mul_pkg::*;
#(
   parameter int MUL_LAT = 4
)
(
   input  logic       clk,
   input  logic       reset,
   input  logic       go,
   input  mul_issue_t issue,
   input  gpr_load_t  gpr_load,
   input  hilo_load_t hilo_load,
   input  mul_done_t  done,
   output int         outstanding
);

   logic [31:0] gpr_shadow [0:(1<<LG_PRF_ENTRIES)-1];
   logic [63:0] hilo_shadow [0:(1<<LG_HILO_PRF_ENTRIES)-1];
   mul_done_t   exp_q [$];
   longint      due_q [$];
   longint      cycle;
   int          test_errors  = 0;
   int          total_errors = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   // expected completion from the operand values seen at issue
   function automatic mul_done_t expected_done(input mul_issue_t op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [63:0] acc);
      mul_done_t       r;
      longint          sa;
      longint          sb;
      longint unsigned ua;
      longint unsigned ub;
      logic [63:0]     p;
      sa = $signed(a);
      sb = $signed(b);
      ua = a;
      ub = b;
      if (op.opcode == MULTU)
         p = ua * ub;
      else
         p = sa * sb;
      r.valid    = 1'b1;
      r.rob_ptr  = op.rob_ptr;
      r.gpr_val  = (op.opcode == MUL);
      r.gpr_ptr  = op.gpr_dst;
      r.hilo_val = (op.opcode != MUL);
      r.hilo_ptr = op.hilo_dst;
      case (op.opcode)
         MADD:    r.y = acc + p;
         MSUB:    r.y = acc - p;
         default: r.y = p;
      endcase
      return r;
   endfunction

   task automatic report_error(input string msg);
      $display("%s", msg);
      test_errors++;
      total_errors++;
   endtask

   task automatic check_field(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
         report_error($sformatf("mismatch done.%s: got %h, expected %h", name, got, exp));
   endtask

   task automatic end_test(input string name);
      if (exp_q.size() != 0)
      begin
         report_error($sformatf("error: %0d operations never completed", exp_q.size()));
         exp_q.delete();
         due_q.delete();
         outstanding = 0;
      end
      if (test_errors == 0)
      begin
         tests_passed++;
         $display("test %s: passed", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic report_counts();
      $display("tests passed: %0d, tests failed: %0d, errors: %0d",
               tests_passed, tests_failed, total_errors);
   endtask

   always @(posedge clk)
   begin : watch
      mul_done_t exp_rec;
      mul_done_t new_rec;
      logic      has_due;
      if (reset)
      begin
         for (int i = 0; i < (1<<LG_PRF_ENTRIES); i++)
            gpr_shadow[i] = '0;
         for (int i = 0; i < (1<<LG_HILO_PRF_ENTRIES); i++)
            hilo_shadow[i] = '0;
         exp_q.delete();
         due_q.delete();
         cycle       = 0;
         outstanding = 0;
      end
      else
      begin
         cycle++;
         has_due = (due_q.size() != 0) && (due_q[0] == cycle);
         if (has_due)
         begin
            exp_rec = exp_q.pop_front();
            void'(due_q.pop_front());
            if (done.valid !== 1'b1)
               report_error($sformatf("error: rob_ptr %h did not complete on time",
                                      exp_rec.rob_ptr));
            else
            begin
               check_field("rob_ptr", done.rob_ptr, exp_rec.rob_ptr);
               check_field("gpr_val", done.gpr_val, exp_rec.gpr_val);
               check_field("gpr_ptr", done.gpr_ptr, exp_rec.gpr_ptr);
               check_field("hilo_val", done.hilo_val, exp_rec.hilo_val);
               check_field("hilo_ptr", done.hilo_ptr, exp_rec.hilo_ptr);
               check_field("y", done.y, exp_rec.y);
            end
         end
         else if (done.valid !== 1'b0)
         begin
            if (exp_q.size() == 0)
               report_error("error: done.valid went high with no operation outstanding");
            else
               report_error("error: a completion arrived before its due cycle");
         end
         // operands as they stand before this edge's writes
         if (go)
            new_rec = expected_done(issue, gpr_shadow[issue.src_a], gpr_shadow[issue.src_b],
                                    hilo_shadow[issue.hilo_src]);
         if (gpr_load.en)
            gpr_shadow[gpr_load.ptr] = gpr_load.data;
         if (hilo_load.en)
            hilo_shadow[hilo_load.ptr] = hilo_load.data;
         // writeback after the loads so it wins on a shared index
         if (has_due && exp_rec.gpr_val)
            gpr_shadow[exp_rec.gpr_ptr] = exp_rec.y[31:0];
         if (has_due && exp_rec.hilo_val)
            hilo_shadow[exp_rec.hilo_ptr] = exp_rec.y;
         if (go)
         begin
            exp_q.push_back(new_rec);
            due_q.push_back(cycle + MUL_LAT + 1);
         end
         outstanding = exp_q.size();
      end
   end

endmodule

`default_nettype wire

// File: mul_pkg.sv
`default_nettype none

package mul_pkg;

   // register and reorder-buffer pointer widths
   localparam int LG_ROB_ENTRIES      = 6;
   localparam int LG_PRF_ENTRIES      = 6;
   localparam int LG_HILO_PRF_ENTRIES = 3;

   typedef logic [LG_ROB_ENTRIES-1:0]      rob_ptr_t;
   typedef logic [LG_PRF_ENTRIES-1:0]      gpr_ptr_t;
   typedef logic [LG_HILO_PRF_ENTRIES-1:0] hilo_ptr_t;

   typedef enum logic [2:0] {
      MUL   = 3'd0,
      MULT  = 3'd1,
      MULTU = 3'd2,
      MADD  = 3'd3,
      MSUB  = 3'd4
   } opcode_t;

   typedef struct packed {
      opcode_t   opcode;
      gpr_ptr_t  src_a;
      gpr_ptr_t  src_b;
      hilo_ptr_t hilo_src;
      gpr_ptr_t  gpr_dst;
      hilo_ptr_t hilo_dst;
      rob_ptr_t  rob_ptr;
   } mul_issue_t;

   // issue fields that ride down the pipeline
   typedef struct packed {
      opcode_t   opcode;
      gpr_ptr_t  gpr_dst;
      hilo_ptr_t hilo_dst;
      rob_ptr_t  rob_ptr;
   } mul_tag_t;

   typedef struct packed {
      logic        valid;
      rob_ptr_t    rob_ptr;
      logic        gpr_val;
      gpr_ptr_t    gpr_ptr;
      logic        hilo_val;
      hilo_ptr_t   hilo_ptr;
      logic [63:0] y;
   } mul_done_t;

   typedef struct packed {
      logic        en;
      gpr_ptr_t    ptr;
      logic [31:0] data;
   } gpr_load_t;

   typedef struct packed {
      logic        en;
      hilo_ptr_t   ptr;
      logic [63:0] data;
   } hilo_load_t;

endpackage

`default_nettype wire

// File: mul_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mul_subsystem
   import mul_pkg::*;
#(
   parameter int MUL_LAT = 4
)
(
   input  logic       clk,
   input  logic       reset,
   input  logic       go,
   input  mul_issue_t issue,
   input  gpr_load_t  gpr_load,
   input  hilo_load_t hilo_load,
   output mul_done_t  done
);

   logic [31:0] src_a;
   logic [31:0] src_b;
   logic [63:0] src_hilo;
   mul_tag_t    tag;

   // fields that follow the operation to writeback
   assign tag.opcode   = issue.opcode;
   assign tag.gpr_dst  = issue.gpr_dst;
   assign tag.hilo_dst = issue.hilo_dst;
   assign tag.rob_ptr  = issue.rob_ptr;

   // operands come back in the issue cycle
   gpr_prf u_gpr_prf
   (
      .clk       (clk),
      .reset     (reset),
      .rd_ptr_a  (issue.src_a),
      .rd_ptr_b  (issue.src_b),
      .rd_data_a (src_a),
      .rd_data_b (src_b),
      .load      (gpr_load),
      .done      (done)
   );

   hilo_prf u_hilo_prf
   (
      .clk     (clk),
      .reset   (reset),
      .rd_ptr  (issue.hilo_src),
      .rd_data (src_hilo),
      .load    (hilo_load),
      .done    (done)
   );

   mul
   #(
      .MUL_LAT (MUL_LAT)
   )
   u_mul
   (
      .clk      (clk),
      .reset    (reset),
      .go       (go),
      .tag      (tag),
      .src_a    (src_a),
      .src_b    (src_b),
      .src_hilo (src_hilo),
      .done     (done)
   );

endmodule

`default_nettype wire

// File: tb_mul_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mul_subsystem
   import mul_pkg::*;
();

   localparam int MUL_LAT    = 4;
   localparam int N_ISSUES   = 1 + 48 + 32 + 200 + 6 + 4;
   localparam int MAX_CYCLES = N_ISSUES * (MUL_LAT + 3) + 200;

   logic        clk;
   logic        reset;
   logic        go;
   mul_issue_t  issue;
   gpr_load_t   gpr_load;
   hilo_load_t  hilo_load;
   mul_done_t   done;
   int          outstanding;
   rob_ptr_t    next_rob;
   int          cycle_count = 0;
   logic [31:0] edge_vals [0:3];
   logic [63:0] acc_vals [0:3];
   int          acc_a [0:3];
   int          acc_b [0:3];

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   mul_subsystem #(.MUL_LAT(MUL_LAT)) dut
   (
      .clk       (clk),
      .reset     (reset),
      .go        (go),
      .issue     (issue),
      .gpr_load  (gpr_load),
      .hilo_load (hilo_load),
      .done      (done)
   );

   mul_checker #(.MUL_LAT(MUL_LAT)) chk
   (
      .clk         (clk),
      .reset       (reset),
      .go          (go),
      .issue       (issue),
      .gpr_load    (gpr_load),
      .hilo_load   (hilo_load),
      .done        (done),
      .outstanding (outstanding)
   );

   task automatic idle(input int n);
      repeat (n)
      begin
         @(negedge clk);
         go           = 1'b0;
         gpr_load.en  = 1'b0;
         hilo_load.en = 1'b0;
      end
   endtask

   task automatic issue_op(input opcode_t op, input gpr_ptr_t a, input gpr_ptr_t b,
                           input hilo_ptr_t h, input gpr_ptr_t gd, input hilo_ptr_t hd);
      @(negedge clk);
      go             = 1'b1;
      issue.opcode   = op;
      issue.src_a    = a;
      issue.src_b    = b;
      issue.hilo_src = h;
      issue.gpr_dst  = gd;
      issue.hilo_dst = hd;
      issue.rob_ptr  = next_rob;
      next_rob       = next_rob + 1'b1;
      gpr_load.en    = 1'b0;
      hilo_load.en   = 1'b0;
   endtask

   task automatic load_gpr(input gpr_ptr_t ptr, input logic [31:0] data);
      @(negedge clk);
      go            = 1'b0;
      gpr_load.en   = 1'b1;
      gpr_load.ptr  = ptr;
      gpr_load.data = data;
      hilo_load.en  = 1'b0;
   endtask

   task automatic load_hilo(input hilo_ptr_t ptr, input logic [63:0] data);
      @(negedge clk);
      go             = 1'b0;
      gpr_load.en    = 1'b0;
      hilo_load.en   = 1'b1;
      hilo_load.ptr  = ptr;
      hilo_load.data = data;
   endtask

   // idle until every issued operation has written back
   task automatic drain();
      idle(1);
      while (outstanding != 0)
         idle(1);
   endtask

   initial
   begin
      int unsigned seed_state;
      seed_state = $urandom(32'he3f0);
      go         = 1'b0;
      issue      = '0;
      gpr_load   = '0;
      hilo_load  = '0;
      next_rob   = '0;
      reset      = 1'b1;
      edge_vals  = '{32'h0, 32'h1, 32'h8000_0000, 32'hffff_ffff};
      acc_vals   = '{64'h0, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, '1};
      // regs 1 to 4 hold edge_vals
      acc_a      = '{4, 3, 3, 2};
      acc_b      = '{4, 3, 2, 4};
      repeat (4) @(negedge clk);
      reset = 1'b0;

      idle(10);
      issue_op(MULT, 0, 0, 0, 0, 1);
      drain();
      chk.end_test("reset and zero operands");

      for (int i = 0; i < 4; i++)
         load_gpr(i + 1, edge_vals[i]);
      for (int k = 0; k < 3; k++)
         for (int i = 0; i < 4; i++)
            for (int j = 0; j < 4; j++)
               issue_op(opcode_t'(k), i + 1, j + 1, 0, 8 + i * 4 + j, j);
      drain();
      chk.end_test("boundary products");

      for (int h = 0; h < 4; h++)
         load_hilo(h, acc_vals[h]);
      for (int op = 0; op < 2; op++)
         for (int h = 0; h < 4; h++)
            for (int p = 0; p < 4; p++)
               issue_op(op == 0 ? MADD : MSUB, acc_a[p], acc_b[p], h, 0, 4 + p);
      drain();
      chk.end_test("multiply-add and multiply-subtract");

      for (int r = 0; r < 64; r++)
         load_gpr(r, $urandom);
      for (int r = 0; r < 8; r++)
         load_hilo(r, {$urandom, $urandom});
      for (int n = 0; n < 200; n++)
         issue_op(opcode_t'($urandom_range(4)), $urandom_range(63), $urandom_range(63),
                  $urandom_range(7), $urandom_range(63), $urandom_range(7));
      drain();
      chk.end_test("back-to-back random issue");

      load_gpr(40, 32'h0001_2345);
      load_gpr(41, 32'hffff_fff3);
      load_gpr(42, 32'h0000_0007);
      issue_op(MUL, 40, 41, 0, 43, 0);
      drain();
      issue_op(MUL, 43, 42, 0, 44, 0);
      drain();
      issue_op(MULT, 44, 42, 0, 0, 6);
      drain();
      issue_op(MADD, 40, 41, 6, 0, 6);
      drain();
      issue_op(MADD, 44, 44, 6, 0, 6);
      drain();
      issue_op(MSUB, 43, 42, 6, 0, 6);
      drain();
      chk.end_test("dependence through writeback");

      // load lands on the same edge as the writeback
      issue_op(MUL, 40, 42, 0, 50, 0);
      idle(MUL_LAT);
      load_gpr(50, 32'hdead_beef);
      drain();
      issue_op(MUL, 50, 42, 0, 51, 0);
      drain();
      issue_op(MULT, 40, 42, 0, 0, 7);
      idle(MUL_LAT);
      load_hilo(7, 64'h0123_4567_89ab_cdef);
      drain();
      issue_op(MADD, 42, 42, 7, 0, 3);
      drain();
      chk.end_test("load and writeback collision");

      chk.report_counts();
      if (chk.total_errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
